// ==== all.f ====
+incdir+tests
rtl/kbd_pkg.sv
rtl/key2ascii.sv
rtl/ps2_rx.sv
rtl/scan_fifo.sv
rtl/kbd_ctrl.sv
rtl/seg_display.sv
rtl/kbd_top.sv
tests/tb_kbd_top.sv

// ==== tests/tb_kbd_ref.svh ====
`ifndef TB_KBD_REF_SVH
`define TB_KBD_REF_SVH

typedef struct packed {
    logic [7:0] code;
    logic [7:0] ascii;
    logic [7:0] count;
    logic       pressed;
    logic       brk;                       // F0 seen, waiting for its key
    logic       ext;                       // E0 seen, next key is dropped
} model_t;

// Set 2 make codes for a to z and 0 to 9, first entry in the top byte
localparam logic [26*8-1:0] LETTER_CODES = {
    8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
    8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
    8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
};
localparam logic [10*8-1:0] DIGIT_CODES = {
    8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
};

// Active low {dp, g, f, e, d, c, b, a} glyphs, F in the top byte down to 0
localparam logic [16*8-1:0] GLYPHS = {
    8'h8E, 8'h86, 8'hA1, 8'hC6, 8'h83, 8'h88, 8'h90, 8'h80,
    8'hF8, 8'h82, 8'h92, 8'h99, 8'hB0, 8'hA4, 8'hF9, 8'hC0
};

function automatic logic [7:0] letter_code(input int idx);
    return LETTER_CODES[8*(25-idx) +: 8];
endfunction

function automatic logic [7:0] ref_ascii(input logic [7:0] code);
    logic [7:0] a;
    int         i;
    a = 8'h00;                             // Unmapped keys give zero
    for (i = 0; i < 26; i++) begin
        if (code == letter_code(i)) a = 8'h61 + 8'(i);
    end
    for (i = 0; i < 10; i++) begin
        if (code == DIGIT_CODES[8*(9-i) +: 8]) a = 8'h30 + 8'(i);
    end
    if (code == 8'h29) a = 8'h20;          // Space
    if (code == 8'h5A) a = 8'h0D;          // Enter
    if (code == 8'h66) a = 8'h08;          // Backspace
    return a;
endfunction

function automatic logic [7:0] digit_seg(input logic lit, input logic [3:0] nib);
    return lit ? GLYPHS[8*nib +: 8] : 8'hFF;
endfunction

// Next key state after one good scan code
function automatic model_t model_step(input model_t s, input logic [7:0] code);
    model_t n;
    n = s;
    if (code == 8'hF0) begin
        n.brk = 1'b1;
    end else if (code == 8'hE0) begin
        n.ext = 1'b1;
    end else if (s.ext) begin
        n.brk = 1'b0;
        n.ext = 1'b0;
    end else if (s.brk) begin
        if (code == s.code) n.pressed = 1'b0;
        n.brk = 1'b0;
    end else if (!s.pressed || code != s.code) begin
        n.code    = code;
        n.ascii   = ref_ascii(code);
        n.pressed = 1'b1;
        n.count   = s.count + 8'd1;
    end
    return n;
endfunction

// One 11-bit frame, data changes while ps2_clk is high
task automatic send_frame(input logic [7:0] code, input logic bad_parity);
    logic [10:0] bits;
    int          i;
    bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
    for (i = 0; i < 11; i++) begin
        @(posedge clk);
        ps2_data <= bits[i];
        repeat (HALF_BIT) @(posedge clk);
        ps2_clk <= 1'b0;
        repeat (HALF_BIT) @(posedge clk);
        ps2_clk <= 1'b1;
    end
    @(posedge clk);
    ps2_data <= 1'b1;
endtask

`endif

// ==== tests/tb_kbd_top.sv ====
module tb_kbd_top;
    import kbd_pkg::*;

    localparam int HALF_BIT        = 20;
    localparam int SETTLE          = 10;
    localparam int RANDOM_CODES    = 200;
    localparam int BURST_FRAMES    = FIFO_DEPTH + 3;
    localparam int DIRECTED_FRAMES = 19;
    localparam int TOTAL_FRAMES    = DIRECTED_FRAMES + BURST_FRAMES + RANDOM_CODES;
    localparam int TIMEOUT_CYCLES  = TOTAL_FRAMES * 11 * 40 * 2;

    localparam logic [31:0] MAPPED_POOL   = {8'h1C, 8'h29, 8'h5A, 8'h45};
    localparam logic [15:0] UNMAPPED_POOL = {8'h76, 8'h0D};

    logic clk;
    logic rst_n;
    logic ps2_clk;
    logic ps2_data;
    seg_t key_lo_seg;
    seg_t key_hi_seg;
    seg_t ascii_lo_seg;
    seg_t ascii_hi_seg;
    seg_t count_lo_seg;
    seg_t count_hi_seg;
    logic is_press;
    logic overflow;
    logic check_req;
    int   cycle_cnt = 0;

    `include "tb_kbd_ref.svh"

    model_t m;

    kbd_top i_kbd_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .key_lo_seg   (key_lo_seg),
        .key_hi_seg   (key_hi_seg),
        .ascii_lo_seg (ascii_lo_seg),
        .ascii_hi_seg (ascii_hi_seg),
        .count_lo_seg (count_lo_seg),
        .count_hi_seg (count_hi_seg),
        .is_press     (is_press),
        .overflow     (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Simulation stopped");
        end
    end

    task automatic check_value(input string name, input logic [7:0] exp,
                               input logic [7:0] act);
        assert (act === exp) else begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic compare_outputs();
        check_value("is_press", {7'd0, m.pressed}, {7'd0, is_press});
        check_value("overflow", 8'h00, {7'd0, overflow}); // Drained one code per cycle
        check_value("key_lo_seg", digit_seg(m.pressed, m.code[3:0]), key_lo_seg);
        check_value("key_hi_seg", digit_seg(m.pressed, m.code[7:4]), key_hi_seg);
        check_value("ascii_lo_seg", digit_seg(m.pressed, m.ascii[3:0]), ascii_lo_seg);
        check_value("ascii_hi_seg", digit_seg(m.pressed, m.ascii[7:4]), ascii_hi_seg);
        check_value("count_lo_seg", digit_seg(m.pressed, m.count[3:0]), count_lo_seg);
        check_value("count_hi_seg", digit_seg(m.pressed, m.count[7:4]), count_hi_seg);
    endtask

    initial begin
        forever begin
            wait (check_req);
            repeat (SETTLE) @(posedge clk);
            @(negedge clk);
            compare_outputs();
            check_req = 1'b0;
        end
    end

    task automatic request_check();
        check_req = 1'b1;
        wait (!check_req);
    endtask

    task automatic send_key(input logic [7:0] code);
        send_frame(code, 1'b0);
        m = model_step(m, code);
        request_check();
    endtask

    initial begin
        logic [7:0]  code;
        int unsigned pick;
        int          i;
        rst_n     = 1'b0;
        ps2_clk   = 1'b1;
        ps2_data  = 1'b1;
        check_req = 1'b0;
        m         = '0;
        void'($urandom(32'hfc68_9153));
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        request_check();                   // Blank display after reset

        send_key(8'h1C);
        send_key(8'hF0);
        send_key(8'h1C);                   // Release blanks the display and keeps the count

        send_key(8'h1C);
        send_key(8'h1C);
        send_key(8'h1C);                   // Typematic repeats
        send_key(8'h32);
        send_key(8'h76);                   // Unmapped key
        send_key(8'hF0);
        send_key(8'h32);                   // Release of a key not held
        send_key(8'hF0);
        send_key(8'h76);
        send_key(8'hE0);
        send_key(8'h1C);
        send_key(8'hE0);
        send_key(8'hF0);
        send_key(8'h1C);

        send_frame(8'h2B, 1'b1);           // Bad parity is dropped
        request_check();
        send_key(8'h2B);

        for (i = 0; i < BURST_FRAMES; i++) begin
            code = letter_code(10 + i);
            send_frame(code, 1'b0);
            m = model_step(m, code);
        end
        request_check();

        for (i = 0; i < RANDOM_CODES; i++) begin
            pick = $urandom % 8;
            case (pick)
                0, 1, 2: code = MAPPED_POOL[8*($urandom % 4) +: 8];
                3:       code = UNMAPPED_POOL[8*($urandom % 2) +: 8];
                4, 5:    code = 8'hF0;
                default: code = 8'hE0;
            endcase
            send_key(code);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== rtl/kbd_top.sv ====
module kbd_top (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          ps2_clk,
    input  logic          ps2_data,
    output kbd_pkg::seg_t key_lo_seg,
    output kbd_pkg::seg_t key_hi_seg,
    output kbd_pkg::seg_t ascii_lo_seg,
    output kbd_pkg::seg_t ascii_hi_seg,
    output kbd_pkg::seg_t count_lo_seg,
    output kbd_pkg::seg_t count_hi_seg,
    output logic          is_press,
    output logic          overflow
);
    import kbd_pkg::*;

    scan_code_t rx_code;
    logic       rx_valid;
    scan_code_t head_code;
    logic       not_empty;
    logic       pop;
    key_event_t evt;

    ps2_rx u_ps2_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .code       (rx_code),
        .code_valid (rx_valid)
    );

    scan_fifo u_scan_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_code   (rx_code),
        .wr_en     (rx_valid),
        .pop       (pop),
        .rd_code   (head_code),
        .not_empty (not_empty),
        .overflow  (overflow)
    );

    kbd_ctrl u_kbd_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_code   (head_code),
        .not_empty (not_empty),
        .pop       (pop),
        .evt       (evt),
        .is_press  (is_press)
    );

    seg_display u_seg_display (
        .evt          (evt),
        .key_lo_seg   (key_lo_seg),
        .key_hi_seg   (key_hi_seg),
        .ascii_lo_seg (ascii_lo_seg),
        .ascii_hi_seg (ascii_hi_seg),
        .count_lo_seg (count_lo_seg),
        .count_hi_seg (count_hi_seg)
    );

endmodule

// ==== rtl/seg_display.sv ====
module seg_display (
    input  kbd_pkg::key_event_t evt,
    output kbd_pkg::seg_t       key_lo_seg,
    output kbd_pkg::seg_t       key_hi_seg,
    output kbd_pkg::seg_t       ascii_lo_seg,
    output kbd_pkg::seg_t       ascii_hi_seg,
    output kbd_pkg::seg_t       count_lo_seg,
    output kbd_pkg::seg_t       count_hi_seg
);
    import kbd_pkg::*;

    seg_t key_lo;
    seg_t key_hi;
    seg_t ascii_lo;
    seg_t ascii_hi;
    seg_t count_lo;
    seg_t count_hi;

    always_comb begin
        key_lo   = hex_to_seg(evt.code[3:0]);
        key_hi   = hex_to_seg(evt.code[7:4]);
        ascii_lo = hex_to_seg(evt.ascii[3:0]);
        ascii_hi = hex_to_seg(evt.ascii[7:4]);
        count_lo = hex_to_seg(evt.count[3:0]);
        count_hi = hex_to_seg(evt.count[7:4]);
    end

    // All digits go dark while no key is held
    assign key_lo_seg   = evt.pressed ? key_lo   : SEG_BLANK;
    assign key_hi_seg   = evt.pressed ? key_hi   : SEG_BLANK;
    assign ascii_lo_seg = evt.pressed ? ascii_lo : SEG_BLANK;
    assign ascii_hi_seg = evt.pressed ? ascii_hi : SEG_BLANK;
    assign count_lo_seg = evt.pressed ? count_lo : SEG_BLANK;
    assign count_hi_seg = evt.pressed ? count_hi : SEG_BLANK;

endmodule

// ==== rtl/kbd_ctrl.sv ====
module kbd_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  kbd_pkg::scan_code_t rd_code,
    input  logic                not_empty,
    output logic                pop,
    output kbd_pkg::key_event_t evt,
    output logic                is_press
);
    import kbd_pkg::*;

    scan_code_t held_code;
    logic [7:0] held_ascii;
    logic [7:0] press_count;
    logic       pressed;
    logic       break_pending;
    logic       ext_pending;
    logic [7:0] lut_ascii;
    logic       is_prefix;
    logic       new_press;

    key2ascii u_key2ascii (
        .code  (rd_code),
        .ascii (lut_ascii)
    );

    assign pop = not_empty;                // Drain one code per cycle

    assign is_prefix = (rd_code == SCAN_BREAK) || (rd_code == SCAN_EXT);

    // A make code that is not a typematic repeat of the held key
    assign new_press = pop && !is_prefix && !ext_pending && !break_pending &&
                       (!pressed || rd_code != held_code);

    always_ff @(posedge clk) begin
        if (new_press) begin
            held_code  <= rd_code;
            held_ascii <= lut_ascii;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            press_count   <= 8'd0;
            pressed       <= 1'b0;
            break_pending <= 1'b0;
            ext_pending   <= 1'b0;
        end else if (pop) begin
            if (rd_code == SCAN_BREAK) begin
                break_pending <= 1'b1;
            end else if (rd_code == SCAN_EXT) begin
                ext_pending <= 1'b1;
            end else if (ext_pending) begin
                break_pending <= 1'b0;     // Extended keys are dropped
                ext_pending   <= 1'b0;
            end else if (break_pending) begin
                if (rd_code == held_code) begin
                    pressed <= 1'b0;
                end
                break_pending <= 1'b0;
                ext_pending   <= 1'b0;
            end else if (new_press) begin
                pressed     <= 1'b1;
                press_count <= press_count + 8'd1;
            end
        end
    end

    assign evt = '{
        code:    held_code,
        ascii:   held_ascii,
        count:   press_count,
        pressed: pressed
    };

    assign is_press = pressed;

endmodule

// ==== rtl/scan_fifo.sv ====
module scan_fifo (
    input  logic                clk,
    input  logic                rst_n,
    input  kbd_pkg::scan_code_t wr_code,
    input  logic                wr_en,
    input  logic                pop,
    output kbd_pkg::scan_code_t rd_code,
    output logic                not_empty,
    output logic                overflow
);
    import kbd_pkg::*;

    scan_code_t         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   fill;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full      = (fill == (FIFO_AW+1)'(FIFO_DEPTH));
    assign not_empty = (fill != '0);
    assign do_pop    = pop & not_empty;
    assign do_push   = wr_en & (~full | do_pop); // A pop frees the slot this cycle
    assign rd_code   = mem[rd_ptr];              // Show-ahead head

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_code;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            overflow <= overflow | (wr_en & ~do_push); // Sticky until reset
        end
    end

endmodule

// ==== rtl/ps2_rx.sv ====
module ps2_rx (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output kbd_pkg::scan_code_t code,
    output logic                code_valid
);
    import kbd_pkg::*;

    logic [1:0]              clk_sync;
    logic [1:0]              data_sync;
    logic                    clk_prev;
    logic                    fall;
    logic [3:0]              bit_cnt;
    logic [10:0]             frame;
    logic [10:0]             frame_next;
    logic [RX_TIMEOUT_W-1:0] idle_cnt;
    logic                    last_bit;
    logic                    frame_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;            // Idle bus is high
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign fall       = clk_prev & ~clk_sync[1];
    assign frame_next = {data_sync[1], frame[10:1]}; // LSB arrives first
    assign last_bit   = (bit_cnt == RX_LAST_BIT);

    // Start low, odd parity over data and parity bit, stop high
    assign frame_ok = ~frame_next[0] & (^frame_next[9:1]) & frame_next[10];

    always_ff @(posedge clk) begin
        if (fall) begin
            frame <= frame_next;
        end
        if (fall && last_bit) begin
            code <= frame_next[8:1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt    <= 4'd0;
            idle_cnt   <= '0;
            code_valid <= 1'b0;
        end else begin
            code_valid <= fall & last_bit & frame_ok;
            if (fall) begin
                idle_cnt <= '0;
                bit_cnt  <= last_bit ? 4'd0 : bit_cnt + 4'd1;
            end else if (bit_cnt != 4'd0 && clk_sync[1]) begin
                if (&idle_cnt) begin
                    bit_cnt  <= 4'd0;      // Keyboard went quiet mid-frame
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end else begin
                idle_cnt <= '0;
            end
        end
    end

endmodule

// ==== rtl/key2ascii.sv ====
module key2ascii (
    input  kbd_pkg::scan_code_t code,
    output logic [7:0]          ascii
);

    // Scan code set 2, lower case only
    always_comb begin
        case (code)
            8'h1C:   ascii = 8'h61;        // a
            8'h32:   ascii = 8'h62;
            8'h21:   ascii = 8'h63;
            8'h23:   ascii = 8'h64;
            8'h24:   ascii = 8'h65;
            8'h2B:   ascii = 8'h66;
            8'h34:   ascii = 8'h67;
            8'h33:   ascii = 8'h68;
            8'h43:   ascii = 8'h69;
            8'h3B:   ascii = 8'h6A;
            8'h42:   ascii = 8'h6B;
            8'h4B:   ascii = 8'h6C;
            8'h3A:   ascii = 8'h6D;
            8'h31:   ascii = 8'h6E;
            8'h44:   ascii = 8'h6F;
            8'h4D:   ascii = 8'h70;
            8'h15:   ascii = 8'h71;
            8'h2D:   ascii = 8'h72;
            8'h1B:   ascii = 8'h73;
            8'h2C:   ascii = 8'h74;
            8'h3C:   ascii = 8'h75;
            8'h2A:   ascii = 8'h76;
            8'h1D:   ascii = 8'h77;
            8'h22:   ascii = 8'h78;
            8'h35:   ascii = 8'h79;
            8'h1A:   ascii = 8'h7A;        // z
            8'h45:   ascii = 8'h30;        // 0
            8'h16:   ascii = 8'h31;
            8'h1E:   ascii = 8'h32;
            8'h26:   ascii = 8'h33;
            8'h25:   ascii = 8'h34;
            8'h2E:   ascii = 8'h35;
            8'h36:   ascii = 8'h36;
            8'h3D:   ascii = 8'h37;
            8'h3E:   ascii = 8'h38;
            8'h46:   ascii = 8'h39;        // 9
            8'h29:   ascii = 8'h20;        // Space
            8'h5A:   ascii = 8'h0D;        // Enter
            8'h66:   ascii = 8'h08;        // Backspace
            default: ascii = 8'h00;
        endcase
    end

endmodule

// ==== rtl/kbd_pkg.sv ====
package kbd_pkg;

    typedef logic [7:0] scan_code_t;
    typedef logic [7:0] seg_t;             // Active low, bit 7 is the decimal point

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;

    localparam int         RX_TIMEOUT_W = 10;    // 1024 idle cycles end a broken frame
    localparam logic [3:0] RX_LAST_BIT  = 4'd10; // Stop bit index

    localparam scan_code_t SCAN_BREAK = 8'hF0;
    localparam scan_code_t SCAN_EXT   = 8'hE0;

    localparam seg_t SEG_BLANK = 8'hFF;

    typedef struct packed {
        scan_code_t code;                  // Held key
        logic [7:0] ascii;                 // Zero when unmapped
        logic [7:0] count;                 // Distinct presses, wraps at 256
        logic       pressed;
    } key_event_t;

    // Segment order is {dp, g, f, e, d, c, b, a}
    function automatic seg_t hex_to_seg(input logic [3:0] nibble);
        seg_t seg;
        case (nibble)
            4'h0:    seg = 8'hC0;
            4'h1:    seg = 8'hF9;
            4'h2:    seg = 8'hA4;
            4'h3:    seg = 8'hB0;
            4'h4:    seg = 8'h99;
            4'h5:    seg = 8'h92;
            4'h6:    seg = 8'h82;
            4'h7:    seg = 8'hF8;
            4'h8:    seg = 8'h80;
            4'h9:    seg = 8'h90;
            4'hA:    seg = 8'h88;
            4'hB:    seg = 8'h83;      // Lower case b
            4'hC:    seg = 8'hC6;
            4'hD:    seg = 8'hA1;      // Lower case d
            4'hE:    seg = 8'h86;
            default: seg = 8'h8E;
        endcase
        return seg;
    endfunction

endpackage
